// ==== verilog/agenPkg.sv ====
/*
 * address-generation package
 * widths, unit and opcode codes, instruction field positions and the
 * packed structs shared by the memory issue pipeline
 */
`default_nettype none

package agenPkg;

	// ========================================
	// widths
	// ========================================

	// operands and effective addresses are full register width
	localparam int AddrW = 80;
	localparam int InstW = 40;
	localparam int UnitW = 3;
	localparam int OpcW = 4;

	// sign-extended displacement of the default load and store forms
	localparam int SdispW = 22;
	// zero-extended displacement of the indexed forms
	localparam int ZdispW = 8;

	// ========================================
	// unit and opcode codes
	// ========================================

	localparam logic [UnitW-1:0] MLdUnit = 3'd4;
	localparam logic [UnitW-1:0] MStUnit = 3'd5;

	// the opcode field only selects a form within the load or store unit
	localparam logic [OpcW-1:0] OpcAmo = 4'd1;
	localparam logic [OpcW-1:0] OpcMlx = 4'd15;
	localparam logic [OpcW-1:0] OpcPush = 4'd12;
	localparam logic [OpcW-1:0] OpcPushc = 4'd13;
	localparam logic [OpcW-1:0] OpcMsx = 4'd14;

	// a push pre-decrements the stack pointer by one 80-bit slot
	localparam logic [AddrW-1:0] PushDecr = 80'd10;

	// ========================================
	// instruction field positions
	// ========================================

	localparam int OpcLo = 6;
	localparam int OpcHi = 9;
	// index scale select
	localparam int ScaleLo = 28;
	localparam int ScaleHi = 30;

	// register block addresses
	localparam int CsrAddrW = 2;
	localparam logic [CsrAddrW-1:0] CsrLo = 2'd0;
	localparam logic [CsrAddrW-1:0] CsrHi = 2'd1;
	localparam logic [CsrAddrW-1:0] CsrCtl = 2'd2;

	// ========================================
	// shared structs
	// ========================================

	// issued memory operation, 203 bits
	typedef struct packed {
		logic [UnitW-1:0] unit;
		logic [InstW-1:0] inst;
		logic [AddrW-1:0] a;
		logic [AddrW-1:0] c;
	} agenOpT;

	// finished request handed to the memory side
	typedef struct packed {
		logic [AddrW-1:0] addr;
		logic isStore;
		logic fault;
	} memReqT;

	// bounds window, inclusive at both ends
	typedef struct packed {
		logic [AddrW-1:0] lo;
		logic [AddrW-1:0] hi;
		logic checkEn;
	} boundsT;

endpackage

`default_nettype wire

// ==== verilog/addrGen.sv ====
/*
 * address generator
 * forms the effective address of a load or store from the base operand,
 * a scaled index and the displacement fields of the instruction word,
 * purely combinational
 */
`timescale 1ns/1ns
`default_nettype none

module addrGen (
	input  agenPkg::agenOpT           op,
	output logic [agenPkg::AddrW-1:0] addr
);

	import agenPkg::*;

	logic [OpcW-1:0] opc;
	logic [2:0] scaleSel;
	logic [AddrW-1:0] idxScaled;

	// raw displacement fields as cut from the instruction
	logic [SdispW-1:0] ldDispRaw;
	logic [SdispW-1:0] stDispRaw;
	logic [ZdispW-1:0] mlxDispRaw;
	logic [ZdispW-1:0] msxDispRaw;

	// the same fields extended to address width
	logic [AddrW-1:0] ldDisp;
	logic [AddrW-1:0] stDisp;
	logic [AddrW-1:0] mlxDisp;
	logic [AddrW-1:0] msxDisp;

	// ========================================
	// field decode
	// ========================================

	assign opc = op.inst[OpcHi:OpcLo];
	assign scaleSel = op.inst[ScaleHi:ScaleLo];

	// ========================================
	// index scaling
	// ========================================

	// powers of two are plain shifts
	// 5, 10 and 15 are built from two shifted copies
	// anything carried past bit 79 wraps away with the address
	always_comb begin
		case (scaleSel)
			3'd1: idxScaled = op.c << 1;
			3'd2: idxScaled = op.c << 2;
			3'd3: idxScaled = op.c << 3;
			3'd4: idxScaled = op.c << 4;
			// times 5
			3'd5: idxScaled = (op.c << 2) + op.c;
			// times 10
			3'd6: idxScaled = (op.c << 3) + (op.c << 1);
			// times 15
			3'd7: idxScaled = (op.c << 4) - op.c;
			default: idxScaled = op.c;
		endcase
	end

	// ========================================
	// displacements
	// ========================================

	// load default form keeps the high part of the immediate in 39:33
	// and the low part in 30:16
	assign ldDispRaw = {op.inst[39:33], op.inst[30:16]};

	// stores need 21:16 for the data register, so the low part moves to 5:0
	assign stDispRaw = {op.inst[39:33], op.inst[30:22], op.inst[5:0]};

	// indexed forms only get a short unsigned offset
	assign mlxDispRaw = {op.inst[34:33], op.inst[21:16]};
	assign msxDispRaw = {op.inst[34:33], op.inst[5:0]};

	// bit 39 is the sign of both long displacements
	assign ldDisp = {{(AddrW-SdispW){ldDispRaw[SdispW-1]}}, ldDispRaw};
	assign stDisp = {{(AddrW-SdispW){stDispRaw[SdispW-1]}}, stDispRaw};
	assign mlxDisp = {{(AddrW-ZdispW){1'b0}}, mlxDispRaw};
	assign msxDisp = {{(AddrW-ZdispW){1'b0}}, msxDispRaw};

	// ========================================
	// form select
	// ========================================

	always_comb begin
		addr = '0;
		case (op.unit)
			MLdUnit: begin
				case (opc)
					// atomics address memory through the base register alone
					OpcAmo: addr = op.a;
					OpcMlx: addr = op.a + idxScaled + mlxDisp;
					default: addr = op.a + ldDisp;
				endcase
			end
			MStUnit: begin
				case (opc)
					// both push forms write just below the stack pointer
					OpcPush, OpcPushc: addr = op.a - PushDecr;
					OpcMsx: addr = op.a + idxScaled + msxDisp;
					default: addr = op.a + stDisp;
				endcase
			end
			// other units never reach memory and get address zero
			default: addr = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/agenCsr.sv ====
/*
 * address check register block
 * holds the lower and upper bounds of the legal address window and the
 * check enable, written by strobe and read back combinationally
 */
`timescale 1ns/1ns
`default_nettype none

module agenCsr (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic                         csrWe,
	input  logic [agenPkg::CsrAddrW-1:0] csrAddr,
	input  logic [agenPkg::AddrW-1:0]    csrWdata,
	output logic [agenPkg::AddrW-1:0]    csrRdata,
	output agenPkg::boundsT              bounds
);

	import agenPkg::*;

	// current window, visible to the issue stage every cycle
	boundsT boundsQ;

	// ========================================
	// write side
	// ========================================

	// a write lands at the next edge and is used from the following cycle on
	// reset leaves the window empty and checking off
	always_ff @(posedge clk) begin
		if (!rstN) begin
			boundsQ <= '0;
		end else if (csrWe) begin
			case (csrAddr)
				CsrLo: boundsQ.lo <= csrWdata;
				CsrHi: boundsQ.hi <= csrWdata;
				// only bit 0 of the control word is implemented
				CsrCtl: boundsQ.checkEn <= csrWdata[0];
				default: boundsQ <= boundsQ;
			endcase
		end
	end

	// ========================================
	// read side
	// ========================================

	// readback follows the address with no register in the path
	always_comb begin
		csrRdata = '0;
		case (csrAddr)
			CsrLo: csrRdata = boundsQ.lo;
			CsrHi: csrRdata = boundsQ.hi;
			CsrCtl: csrRdata = {{(AddrW-1){1'b0}}, boundsQ.checkEn};
			// the unused slot reads as zero
			default: csrRdata = '0;
		endcase
	end

	assign bounds = boundsQ;

endmodule

`default_nettype wire

// ==== verilog/memIssueStage.sv ====
/*
 * memory issue stage
 * two-stage pipe that registers an issued operation, forms its effective
 * address and registers the request with its store and fault flags
 */
`timescale 1ns/1ns
`default_nettype none

module memIssueStage (
	input  logic            clk,
	input  logic            rstN,
	input  logic            issueValid,
	input  agenPkg::agenOpT issueOp,
	input  agenPkg::boundsT bounds,
	output logic            reqValid,
	output agenPkg::memReqT req
);

	import agenPkg::*;

	// first stage holds the issued operation
	logic opValid;
	agenOpT opQ;

	// address and flags formed during the second cycle
	logic [AddrW-1:0] effAddr;
	logic belowLo;
	logic aboveHi;
	logic faultNext;
	logic isStoreNext;

	// ========================================
	// stage 1, operation register
	// ========================================

	always_ff @(posedge clk) begin
		if (!rstN) begin
			opValid <= 1'b0;
		end else begin
			opValid <= issueValid;
		end
	end

	// the payload is only loaded on a real issue
	always_ff @(posedge clk) begin
		if (issueValid) begin
			opQ <= issueOp;
		end
	end

	// ========================================
	// address and bounds check
	// ========================================

	addrGen uAddrGen (
		.op  (opQ),
		.addr(effAddr)
	);

	// window edges are legal, both compares are unsigned
	// the bounds seen here are the ones current in this cycle
	assign belowLo = effAddr < bounds.lo;
	assign aboveHi = effAddr > bounds.hi;
	assign faultNext = bounds.checkEn & (belowLo | aboveHi);

	assign isStoreNext = (opQ.unit == MStUnit);

	// ========================================
	// stage 2, request register
	// ========================================

	always_ff @(posedge clk) begin
		if (!rstN) begin
			reqValid <= 1'b0;
		end else begin
			reqValid <= opValid;
		end
	end

	// the request holds its last value between strobes
	always_ff @(posedge clk) begin
		if (opValid) begin
			req <= '{addr: effAddr, isStore: isStoreNext, fault: faultNext};
		end
	end

endmodule

`default_nettype wire

// ==== verilog/memAgenTop.sv ====
/*
 * memory address-generation slice
 * bounds register block beside the two-stage issue pipe
 */
`timescale 1ns/1ns
`default_nettype none

module memAgenTop (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic                         issueValid,
	input  agenPkg::agenOpT              issueOp,
	input  logic                         csrWe,
	input  logic [agenPkg::CsrAddrW-1:0] csrAddr,
	input  logic [agenPkg::AddrW-1:0]    csrWdata,
	output logic [agenPkg::AddrW-1:0]    csrRdata,
	output logic                         reqValid,
	output agenPkg::memReqT              req
);

	import agenPkg::*;

	// window shared between the register block and the check
	boundsT bounds;

	agenCsr uAgenCsr (
		.clk     (clk),
		.rstN    (rstN),
		.csrWe   (csrWe),
		.csrAddr (csrAddr),
		.csrWdata(csrWdata),
		.csrRdata(csrRdata),
		.bounds  (bounds)
	);

	// requests come out two cycles after issue
	memIssueStage uMemIssueStage (
		.clk       (clk),
		.rstN      (rstN),
		.issueValid(issueValid),
		.issueOp   (issueOp),
		.bounds    (bounds),
		.reqValid  (reqValid),
		.req       (req)
	);

endmodule

`default_nettype wire

// ==== dv/memAgenTop_assert.sv ====
/*
 * assertions for the address-generation slice
 * request timing against issue, reset state and fault legality
 */
`timescale 1ns/1ns
`default_nettype none

module memAgenTopAssert (
	input logic            clk,
	input logic            rstN,
	input logic            issueValid,
	input logic            reqValid,
	input agenPkg::memReqT req,
	input agenPkg::boundsT bounds
);

	// ========================================
	// request timing
	// ========================================

	// every issue turns into a request two edges later
	assert property (@(posedge clk) disable iff (!rstN) issueValid |-> ##2 reqValid)
		else $error("issue at %0t was not followed by a request 2 cycles later", $time);

	// and no request shows up without that issue
	assert property (@(posedge clk) disable iff (!rstN) reqValid |-> $past(issueValid, 2))
		else $error("request at %0t without an issue 2 cycles earlier", $time);

	// reset clears the output strobe on the very next edge
	assert property (@(posedge clk) !rstN |=> !reqValid)
		else $error("reqValid high in the cycle after reset at %0t", $time);

	// ========================================
	// fault legality
	// ========================================

	// the window in force while the address was formed decides the fault
	assert property (@(posedge clk) disable iff (!rstN)
			reqValid && req.fault |-> $past(bounds.checkEn))
		else $error("fault raised with checking disabled at %0t", $time);

endmodule

bind memAgenTop memAgenTopAssert uMemAgenTopAssert (
	.clk       (clk),
	.rstN      (rstN),
	.issueValid(issueValid),
	.reqValid  (reqValid),
	.req       (req),
	.bounds    (bounds)
);

`default_nettype wire

// ==== dv/memAgenTb.sv ====
/*
 * testbench for the memory address-generation slice
 * drives a table of issued operations through the DUT, predicts every
 * request from the address rules and checks the bounds register block
 */
`timescale 1ns/1ns
`default_nettype none

module memAgenTb;

	import agenPkg::*;

	localparam int ClkPeriod = 10;
	// window programmed into the register block for the whole run
	localparam logic [AddrW-1:0] WinLo = 80'h4000;
	localparam logic [AddrW-1:0] WinHi = 80'h8000;

	logic clk;
	logic rstN;
	logic issueValid;
	agenOpT issueOp;
	logic csrWe;
	logic [CsrAddrW-1:0] csrAddr;
	logic [AddrW-1:0] csrWdata;
	logic [AddrW-1:0] csrRdata;
	logic reqValid;
	memReqT req;

	integer seed = 32'h9b78aa89;
	int errCount = 0;
	int checkCount = 0;
	bit tableReady = 1'b0;
	int splitIdx;

	// stimulus table, one entry per issued operation
	string tName[$];
	agenOpT tOp[$];
	memReqT tExp[$];

	// requests still owed by the DUT, oldest first
	memReqT expQ[$];
	string nameQ[$];
	memReqT gotExp;
	string gotName;

	memAgenTop dut (
		.clk       (clk),
		.rstN      (rstN),
		.issueValid(issueValid),
		.issueOp   (issueOp),
		.csrWe     (csrWe),
		.csrAddr   (csrAddr),
		.csrWdata  (csrWdata),
		.csrRdata  (csrRdata),
		.reqValid  (reqValid),
		.req       (req)
	);

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	// ========================================
	// reference model
	// ========================================

	function automatic logic [AddrW-1:0] scaleFactor(input logic [2:0] sel);
		case (sel)
			3'd0: return 80'd1;
			3'd1: return 80'd2;
			3'd2: return 80'd4;
			3'd3: return 80'd8;
			3'd4: return 80'd16;
			3'd5: return 80'd5;
			3'd6: return 80'd10;
			default: return 80'd15;
		endcase
	endfunction

	function automatic memReqT expectReq(input agenOpT op, input logic en);
		logic [3:0] opc;
		logic [AddrW-1:0] scaled;
		logic [AddrW-1:0] ea;
		logic [21:0] sdisp;
		logic [7:0] zdisp;
		memReqT r;
		opc = op.inst[9:6];
		scaled = op.c * scaleFactor(op.inst[30:28]);
		ea = '0;
		if (op.unit == MLdUnit) begin
			zdisp = {op.inst[34:33], op.inst[21:16]};
			sdisp = {op.inst[39:33], op.inst[30:16]};
			if (opc == OpcAmo) ea = op.a;
			else if (opc == OpcMlx) ea = op.a + scaled + {72'd0, zdisp};
			else ea = op.a + {{58{sdisp[21]}}, sdisp};
		end else if (op.unit == MStUnit) begin
			zdisp = {op.inst[34:33], op.inst[5:0]};
			sdisp = {op.inst[39:33], op.inst[30:22], op.inst[5:0]};
			if (opc == OpcPush || opc == OpcPushc) ea = op.a - 80'd10;
			else if (opc == OpcMsx) ea = op.a + scaled + {72'd0, zdisp};
			else ea = op.a + {{58{sdisp[21]}}, sdisp};
		end
		r.addr = ea;
		r.isStore = (op.unit == MStUnit);
		r.fault = en && (ea < WinLo || ea > WinHi);
		return r;
	endfunction

	// ========================================
	// table building
	// ========================================

	function automatic logic [AddrW-1:0] rand80();
		logic [95:0] r;
		r = {$random(seed), $random(seed), $random(seed)};
		return r[AddrW-1:0];
	endfunction

	// random instruction word with the opcode and scale fields forced
	function automatic logic [InstW-1:0] makeInst(input logic [3:0] opc, input logic [2:0] sel);
		logic [63:0] r;
		logic [InstW-1:0] w;
		r = {$random(seed), $random(seed)};
		w = r[InstW-1:0];
		w[9:6] = opc;
		w[30:28] = sel;
		return w;
	endfunction

	task automatic addEntry(input string name, input logic [2:0] unit, input logic [39:0] inst,
			input logic [79:0] a, input logic [79:0] c, input logic en);
		agenOpT op;
		op.unit = unit;
		op.inst = inst;
		op.a = a;
		op.c = c;
		tName.push_back(name);
		tOp.push_back(op);
		tExp.push_back(expectReq(op, en));
	endtask

	// ========================================
	// bus tasks and checks
	// ========================================

	task automatic checkVal(input string name, input logic [81:0] exp, input logic [81:0] act);
		checkCount++;
		if (act !== exp) begin
			errCount++;
			$display("FAIL %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic writeCsr(input logic [1:0] addr, input logic [79:0] data);
		@(posedge clk);
		#1;
		csrWe = 1'b1;
		csrAddr = addr;
		csrWdata = data;
		@(posedge clk);
		#1;
		csrWe = 1'b0;
		csrWdata = '0;
	endtask

	// readback is combinational, so it is sampled half a cycle later
	task automatic readCheck(input string name, input logic [1:0] addr, input logic [79:0] exp);
		@(posedge clk);
		#1;
		csrAddr = addr;
		@(negedge clk);
		checkVal(name, {2'b00, exp}, {2'b00, csrRdata});
	endtask

	// entries go out back to back, one per cycle
	task automatic applyTable(input int first, input int last);
		for (int i = first; i < last; i++) begin
			@(posedge clk);
			#1;
			issueValid = 1'b1;
			issueOp = tOp[i];
			expQ.push_back(tExp[i]);
			nameQ.push_back(tName[i]);
		end
		@(posedge clk);
		#1;
		issueValid = 1'b0;
		issueOp = '0;
	endtask

	task automatic drain();
		while (expQ.size() != 0) @(posedge clk);
	endtask

	// outputs are registered on the rising edge and read on the falling one
	always @(negedge clk) begin
		if (rstN && reqValid) begin
			if (expQ.size() == 0) begin
				errCount++;
				$display("request seen at %0t with no operation outstanding", $time);
			end else begin
				gotExp = expQ.pop_front();
				gotName = nameQ.pop_front();
				checkVal(gotName, gotExp, req);
			end
		end
	end

	initial begin
		wait (tableReady);
		#((tName.size() * 4 + 200) * ClkPeriod);
		$display("timeout with %0d requests still outstanding", expQ.size());
		$display(">>> FAIL");
		$finish;
	end

	// ========================================
	// main sequence
	// ========================================

	initial begin
		rstN = 1'b0;
		issueValid = 1'b0;
		issueOp = '0;
		csrWe = 1'b0;
		csrAddr = '0;
		csrWdata = '0;

		// every scale and form, the push wraps and the other units run with checking off
		for (int s = 0; s < 8; s++) begin
			addEntry($sformatf("mlx scale sel %0d", s), MLdUnit, makeInst(OpcMlx, 3'(s)),
				rand80(), rand80(), 1'b0);
			addEntry($sformatf("msx scale sel %0d", s), MStUnit, makeInst(OpcMsx, 3'(s)),
				rand80(), rand80(), 1'b0);
		end
		// bit 39 carries the sign of the long displacement
		addEntry("load disp pos", MLdUnit, makeInst(4'd3, 3'd2) & 40'h7f_ffff_ffff,
			rand80(), '0, 1'b0);
		addEntry("load disp neg", MLdUnit, makeInst(4'd3, 3'd5) | 40'h80_0000_0000,
			80'h100, '0, 1'b0);
		addEntry("store disp pos", MStUnit, makeInst(4'd7, 3'd1) & 40'h7f_ffff_ffff,
			rand80(), '0, 1'b0);
		addEntry("store disp neg", MStUnit, makeInst(4'd7, 3'd3) | 40'h80_0000_0000,
			80'h20, '0, 1'b0);
		addEntry("amo base only", MLdUnit, makeInst(OpcAmo, 3'd7), rand80(), rand80(), 1'b0);
		addEntry("push random", MStUnit, makeInst(OpcPush, 3'd0), rand80(), rand80(), 1'b0);
		addEntry("push wrap", MStUnit, makeInst(OpcPush, 3'd4), 80'd4, '0, 1'b0);
		addEntry("pushc to zero", MStUnit, makeInst(OpcPushc, 3'd0), 80'd10, '0, 1'b0);
		addEntry("pushc wrap", MStUnit, makeInst(OpcPushc, 3'd6), 80'd0, '0, 1'b0);
		addEntry("unit 0 zero", 3'd0, makeInst(OpcAmo, 3'd0), rand80(), rand80(), 1'b0);
		addEntry("unit 7 zero", 3'd7, makeInst(4'd3, 3'd1), rand80(), rand80(), 1'b0);
		addEntry("no check far low", MLdUnit, makeInst(OpcAmo, 3'd0), 80'h1, '0, 1'b0);
		splitIdx = tName.size();

		// addresses below, on the edges of, inside and above the window with checking on
		addEntry("below lo", MLdUnit, makeInst(OpcAmo, 3'd0), WinLo - 80'd1, '0, 1'b1);
		addEntry("at lo", MLdUnit, makeInst(OpcAmo, 3'd0), WinLo, '0, 1'b1);
		addEntry("inside", MLdUnit, makeInst(OpcAmo, 3'd0), 80'h6000, '0, 1'b1);
		addEntry("at hi", MLdUnit, makeInst(OpcAmo, 3'd0), WinHi, '0, 1'b1);
		addEntry("above hi", MLdUnit, makeInst(OpcAmo, 3'd0), WinHi + 80'd1, '0, 1'b1);
		addEntry("push onto lo", MStUnit, makeInst(OpcPush, 3'd0), WinLo + 80'd10, '0, 1'b1);
		addEntry("push below lo", MStUnit, makeInst(OpcPushc, 3'd0), WinLo + 80'd9, '0, 1'b1);
		addEntry("unit 0 checked", 3'd0, makeInst(4'd3, 3'd0), rand80(), '0, 1'b1);
		tableReady = 1'b1;

		repeat (5) @(posedge clk);
		#1;
		rstN = 1'b1;

		readCheck("reset lo", CsrLo, '0);
		readCheck("reset hi", CsrHi, '0);
		readCheck("reset ctl", CsrCtl, '0);
		writeCsr(CsrLo, WinLo);
		writeCsr(CsrHi, WinHi);
		readCheck("readback lo", CsrLo, WinLo);
		readCheck("readback hi", CsrHi, WinHi);

		applyTable(0, splitIdx);
		drain();

		// only bit 0 of the control word is kept
		writeCsr(CsrCtl, 80'h3);
		readCheck("readback ctl", CsrCtl, 80'd1);
		readCheck("unused slot", 2'd3, '0);

		applyTable(splitIdx, tName.size());
		drain();
		repeat (3) @(posedge clk);

		$display("%0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/agenPkg.sv
verilog/addrGen.sv
verilog/agenCsr.sv
verilog/memIssueStage.sv
verilog/memAgenTop.sv
dv/memAgenTop_assert.sv
dv/memAgenTb.sv

// ==== Makefile ====
# Verilator build for the memory address-generation slice

TOP := memAgenTb
OBJ := obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir $(OBJ) -o $(TOP)

# the log decides the verdict, the simulator exit code is not trusted alone
run: build
	./$(OBJ)/$(TOP) | tee sim.log
	@grep -q ">>> PASS" sim.log || (echo "simulation did not pass, see sim.log" && exit 1)

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

clean:
	rm -rf $(OBJ) sim.log
